// File: hdl/isa_pkg.sv
package isa_pkg;

    // ------------------------------------------------------------------
    // Widths with a meaning
    // ------------------------------------------------------------------
    typedef logic [31:0] word_t;     // Data word
    typedef logic [31:0] pc_t;       // Instruction word address
    typedef logic [4:0]  reg_idx_t;  // Register index
    typedef logic [4:0]  shamt_t;    // Shift amount
    typedef logic [16:0] imm_t;      // Raw immediate field

    // Primary opcode, bits 31..27
    typedef enum logic [4:0] {
        op_alu  = 5'b00000,  // R-type, function in aluop field
        op_j    = 5'b00001,
        op_bne  = 5'b00010,
        op_jal  = 5'b00011,
        op_jr   = 5'b00100,
        op_addi = 5'b00101,
        op_blt  = 5'b00110,
        op_sw   = 5'b00111,
        op_lw   = 5'b01000
    } opcode_e;

    // R-type function codes
    typedef enum logic [4:0] {
        alu_add = 5'b00000,
        alu_sub = 5'b00001,
        alu_and = 5'b00010,
        alu_or  = 5'b00011,
        alu_sll = 5'b00100,
        alu_sra = 5'b00101
    } alu_op_e;

    // Field positions
    localparam int OPCODE_HI = 31;
    localparam int OPCODE_LO = 27;
    localparam int RD_HI     = 26;
    localparam int RD_LO     = 22;
    localparam int RS_HI     = 21;
    localparam int RS_LO     = 17;
    localparam int RT_HI     = 16;
    localparam int RT_LO     = 12;
    localparam int SHAMT_HI  = 11;
    localparam int SHAMT_LO  = 7;
    localparam int ALUOP_HI  = 6;
    localparam int ALUOP_LO  = 2;
    localparam int IMM_HI    = 16;
    localparam int IMM_LO    = 0;
    localparam int TARGET_HI = 26;
    localparam int TARGET_LO = 0;

    localparam int       NUM_REGS = 32;
    localparam reg_idx_t LINK_REG = 5'd31;  // jal destination
    localparam pc_t      RESET_PC = 32'd0;

endpackage

// File: hdl/pipe_pkg.sv
package pipe_pkg;

    // Decoded control set, travels with the instruction
    typedef struct packed {
        isa_pkg::alu_op_e alu_op;
        isa_pkg::shamt_t  shamt;
        logic             use_imm;     // ALU B from immediate
        logic             reg_write;
        logic             mem_write;
        logic             mem_to_reg;  // Load
        logic             is_bne;
        logic             is_blt;
        logic             is_j;
        logic             is_jal;
        logic             is_jr;
    } ctrl_t;

    typedef struct packed {
        logic         valid;
        isa_pkg::pc_t pc;
        isa_pkg::word_t instr;
    } fd_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::pc_t       pc;
        ctrl_t              ctrl;
        isa_pkg::reg_idx_t  dst;
        isa_pkg::reg_idx_t  src_a;  // Index read on port A, 0 if unused
        isa_pkg::reg_idx_t  src_b;  // Index read on port B, 0 if unused
        isa_pkg::word_t     op_a;
        isa_pkg::word_t     op_b;
        isa_pkg::word_t     imm;    // Sign-extended imm or jump target
    } dx_t;

    typedef struct packed {
        logic              valid;
        ctrl_t             ctrl;
        isa_pkg::reg_idx_t dst;
        isa_pkg::word_t    result;
        isa_pkg::word_t    store_data;
    } xm_t;

    typedef struct packed {
        logic              valid;
        logic              reg_write;
        logic              mem_to_reg;
        isa_pkg::reg_idx_t dst;
        isa_pkg::word_t    result;
        isa_pkg::word_t    load_data;
    } mw_t;

    typedef struct packed {
        isa_pkg::pc_t   addr;
        isa_pkg::word_t wdata;
        logic           wren;
    } dmem_req_t;

    typedef struct packed {
        logic              en;
        isa_pkg::reg_idx_t idx;
        isa_pkg::word_t    data;
    } wb_t;

    typedef struct packed {
        logic         taken;
        isa_pkg::pc_t target;
    } redirect_t;

    // Operand bypass source
    typedef enum logic [1:0] {
        fwd_none = 2'd0,
        fwd_xm   = 2'd1,
        fwd_mw   = 2'd2
    } fwd_sel_e;

endpackage

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                stall,      // Load-use hold
    input  logic                flush,      // Squash the word being fetched
    input  pipe_pkg::redirect_t redirect,
    output isa_pkg::pc_t        imem_addr,
    input  isa_pkg::word_t      imem_data,
    output pipe_pkg::fd_t       fd
);

    isa_pkg::pc_t pc;
    isa_pkg::pc_t pc_next;

    // Static not-taken, execute overrides
    assign pc_next   = redirect.taken ? redirect.target : pc + 32'd1;
    assign imem_addr = pc;   // Word comes back in the same cycle

    always_ff @(posedge clock) begin
        if (!stall || redirect.taken) begin
            pc <= pc_next;
        end
        if (flush) begin
            fd.valid <= 1'b0;                   // Wrong-path word dropped
        end else if (!stall) begin
            fd.valid <= 1'b1;
            fd.pc    <= pc;
            fd.instr <= imem_data;
        end
        if (!rst_n) begin
            pc       <= isa_pkg::RESET_PC;
            fd.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              flush,
    input  pipe_pkg::fd_t     fd,
    output isa_pkg::reg_idx_t rs_idx,   // Register file port A
    output isa_pkg::reg_idx_t rt_idx,   // Register file port B
    input  isa_pkg::word_t    rs_data,
    input  isa_pkg::word_t    rt_data,
    output pipe_pkg::dx_t     dx
);

    isa_pkg::opcode_e  opcode;
    isa_pkg::reg_idx_t rd, rs, rt;
    isa_pkg::imm_t     imm;
    isa_pkg::word_t    imm_ext;
    isa_pkg::reg_idx_t dst, src_a, src_b;
    pipe_pkg::ctrl_t   ctrl;

    // ------------------------------------------------------------------
    // Field split and control
    // ------------------------------------------------------------------
    always_comb begin
        opcode = isa_pkg::opcode_e'(fd.instr[isa_pkg::OPCODE_HI:isa_pkg::OPCODE_LO]);
        rd     = fd.instr[isa_pkg::RD_HI:isa_pkg::RD_LO];
        rs     = fd.instr[isa_pkg::RS_HI:isa_pkg::RS_LO];
        rt     = fd.instr[isa_pkg::RT_HI:isa_pkg::RT_LO];
        imm    = fd.instr[isa_pkg::IMM_HI:isa_pkg::IMM_LO];
        imm_ext = {{(31 - isa_pkg::IMM_HI){imm[isa_pkg::IMM_HI]}}, imm};   // Sign extend
        ctrl       = '0;
        ctrl.shamt = fd.instr[isa_pkg::SHAMT_HI:isa_pkg::SHAMT_LO];
        dst   = rd;
        src_a = rs;
        src_b = '0;     // Unused port reads r0, never matches a hazard
        case (opcode)
            isa_pkg::op_alu: begin
                ctrl.alu_op    = isa_pkg::alu_op_e'(fd.instr[isa_pkg::ALUOP_HI:isa_pkg::ALUOP_LO]);
                ctrl.reg_write = 1'b1;
                src_b          = rt;
            end
            isa_pkg::op_addi: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            isa_pkg::op_lw: begin
                ctrl.use_imm    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            isa_pkg::op_sw: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                src_b          = rd;    // Store data comes from rd
            end
            isa_pkg::op_bne, isa_pkg::op_blt: begin
                ctrl.is_bne = (opcode == isa_pkg::op_bne);
                ctrl.is_blt = (opcode == isa_pkg::op_blt);
                src_a       = rd;       // Compare rd against rs
                src_b       = rs;
            end
            isa_pkg::op_j, isa_pkg::op_jal: begin
                ctrl.is_j      = (opcode == isa_pkg::op_j);
                ctrl.is_jal    = (opcode == isa_pkg::op_jal);
                ctrl.reg_write = (opcode == isa_pkg::op_jal);
                dst            = isa_pkg::LINK_REG;
                src_a          = '0;
                imm_ext = {{(31 - isa_pkg::TARGET_HI){1'b0}},
                           fd.instr[isa_pkg::TARGET_HI:isa_pkg::TARGET_LO]};
            end
            isa_pkg::op_jr: begin
                ctrl.is_jr = 1'b1;
                src_a      = rd;        // Return address held in rd
            end
            default: src_a = '0;        // Unknown opcode runs as a nop
        endcase
        if (!fd.valid) begin
            src_a = '0;                 // Empty slot, keep hazard unit quiet
            src_b = '0;
        end
    end

    assign rs_idx = src_a;
    assign rt_idx = src_b;

    // ------------------------------------------------------------------
    // DX register, bubble on stall or flush
    // ------------------------------------------------------------------
    always_ff @(posedge clock) begin
        dx.valid <= fd.valid && !stall && !flush;
        dx.pc    <= fd.pc;
        dx.ctrl  <= ctrl;
        dx.dst   <= dst;
        dx.src_a <= src_a;
        dx.src_b <= src_b;
        dx.op_a  <= rs_data;
        dx.op_b  <= rt_data;
        dx.imm   <= imm_ext;
        if (!rst_n) begin
            dx.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              clock,
    input  logic              rst_n,
    input  isa_pkg::reg_idx_t rs_idx,
    input  isa_pkg::reg_idx_t rt_idx,
    output isa_pkg::word_t    rs_data,
    output isa_pkg::word_t    rt_data,
    input  pipe_pkg::wb_t     wb
);

    isa_pkg::word_t regs [isa_pkg::NUM_REGS];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.idx != '0) begin
            regs[wb.idx] <= wb.data;    // r0 stays zero
        end
    end

    // Write-through so decode sees the value retiring this cycle
    always_comb begin
        rs_data = (wb.en && wb.idx == rs_idx) ? wb.data : regs[rs_idx];
        rt_data = (wb.en && wb.idx == rt_idx) ? wb.data : regs[rt_idx];
        if (rs_idx == '0) rs_data = '0;
        if (rt_idx == '0) rt_data = '0;
    end

endmodule

// File: hdl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  isa_pkg::reg_idx_t  fd_src_a,
    input  isa_pkg::reg_idx_t  fd_src_b,
    input  isa_pkg::reg_idx_t  dx_src_a,
    input  isa_pkg::reg_idx_t  dx_src_b,
    input  isa_pkg::reg_idx_t  dx_dst,
    input  isa_pkg::reg_idx_t  xm_dst,
    input  isa_pkg::reg_idx_t  mw_dst,
    input  logic               dx_is_load,
    input  logic               xm_write,
    input  logic               mw_write,
    input  pipe_pkg::redirect_t redirect,
    output logic               stall,
    output logic               flush_fd,
    output logic               flush_dx,
    output pipe_pkg::fwd_sel_e fwd_a,
    output pipe_pkg::fwd_sel_e fwd_b
);

    logic load_use;

    // Youngest producer wins, r0 is hard zero
    function automatic pipe_pkg::fwd_sel_e pick(input isa_pkg::reg_idx_t src,
                                                input isa_pkg::reg_idx_t xm_d,
                                                input logic xm_w,
                                                input isa_pkg::reg_idx_t mw_d,
                                                input logic mw_w);
        if (src == '0) return pipe_pkg::fwd_none;
        if (xm_w && xm_d == src) return pipe_pkg::fwd_xm;
        if (mw_w && mw_d == src) return pipe_pkg::fwd_mw;
        return pipe_pkg::fwd_none;
    endfunction

    // Load result not ready until MW, hold decode one cycle
    assign load_use = dx_is_load && dx_dst != '0 &&
                      (dx_dst == fd_src_a || dx_dst == fd_src_b);

    assign stall    = load_use && !redirect.taken;  // Wrong path anyway
    assign flush_fd = redirect.taken;
    assign flush_dx = redirect.taken;

    assign fwd_a = pick(dx_src_a, xm_dst, xm_write, mw_dst, mw_write);
    assign fwd_b = pick(dx_src_b, xm_dst, xm_write, mw_dst, mw_write);

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                clock,
    input  logic                rst_n,
    input  pipe_pkg::dx_t       dx,
    input  pipe_pkg::fwd_sel_e  fwd_a,
    input  pipe_pkg::fwd_sel_e  fwd_b,
    input  pipe_pkg::wb_t       mw_bypass,
    output pipe_pkg::redirect_t redirect,
    output pipe_pkg::xm_t       xm
);

    isa_pkg::word_t a, b, alu_b, alu_out;
    isa_pkg::pc_t   pc_inc;
    logic           br_cond;

    function automatic isa_pkg::word_t bypass(input pipe_pkg::fwd_sel_e sel,
                                              input isa_pkg::word_t own,
                                              input isa_pkg::word_t from_xm,
                                              input isa_pkg::word_t from_mw);
        case (sel)
            pipe_pkg::fwd_xm: return from_xm;
            pipe_pkg::fwd_mw: return from_mw;
            default:          return own;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Operands and ALU
    // ------------------------------------------------------------------
    assign a      = bypass(fwd_a, dx.op_a, xm.result, mw_bypass.data);
    assign b      = bypass(fwd_b, dx.op_b, xm.result, mw_bypass.data);
    assign alu_b  = dx.ctrl.use_imm ? dx.imm : b;
    assign pc_inc = dx.pc + 32'd1;

    always_comb begin
        case (dx.ctrl.alu_op)
            isa_pkg::alu_sub: alu_out = a - alu_b;
            isa_pkg::alu_and: alu_out = a & alu_b;
            isa_pkg::alu_or:  alu_out = a | alu_b;
            isa_pkg::alu_sll: alu_out = a << dx.ctrl.shamt;
            isa_pkg::alu_sra: alu_out = isa_pkg::word_t'($signed(a) >>> dx.ctrl.shamt);
            default:          alu_out = a + alu_b;  // add, addi, address calc
        endcase
    end

    // ------------------------------------------------------------------
    // Branch and jump resolution
    // ------------------------------------------------------------------
    assign br_cond = (dx.ctrl.is_bne && a != b) ||
                     (dx.ctrl.is_blt && $signed(a) < $signed(b));   // rd < rs

    always_comb begin
        redirect.taken = dx.valid && (br_cond || dx.ctrl.is_j || dx.ctrl.is_jal ||
                                      dx.ctrl.is_jr);
        if (dx.ctrl.is_jr) begin
            redirect.target = a;                    // Register target
        end else if (dx.ctrl.is_j || dx.ctrl.is_jal) begin
            redirect.target = dx.imm;               // Absolute target
        end else begin
            redirect.target = pc_inc + dx.imm;      // PC relative
        end
    end

    // XM register
    always_ff @(posedge clock) begin
        xm.valid      <= dx.valid;
        xm.ctrl       <= dx.ctrl;
        xm.dst        <= dx.dst;
        xm.result     <= dx.ctrl.is_jal ? pc_inc : alu_out;  // Link value
        xm.store_data <= b;
        if (!rst_n) begin
            xm.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic                clock,
    input  logic                rst_n,
    input  pipe_pkg::xm_t       xm,
    output pipe_pkg::dmem_req_t dmem,
    input  isa_pkg::word_t      dmem_rdata,
    output pipe_pkg::wb_t       wb
);

    pipe_pkg::mw_t mw;

    // Data memory request, quiet for empty slots
    always_comb begin
        dmem.wren  = xm.valid && xm.ctrl.mem_write;
        dmem.addr  = xm.valid ? xm.result : '0;
        dmem.wdata = xm.valid ? xm.store_data : '0;
    end

    always_ff @(posedge clock) begin
        mw.valid      <= xm.valid;
        mw.reg_write  <= xm.ctrl.reg_write;
        mw.mem_to_reg <= xm.ctrl.mem_to_reg;
        mw.dst        <= xm.dst;
        mw.result     <= xm.result;
        mw.load_data  <= dmem_rdata;    // Same-cycle read data
        if (!rst_n) begin
            mw.valid <= 1'b0;
        end
    end

    // Write-back select
    always_comb begin
        wb.en   = mw.valid && mw.reg_write && mw.dst != '0;
        wb.idx  = wb.en ? mw.dst : '0;
        wb.data = '0;
        if (wb.en) begin
            wb.data = mw.mem_to_reg ? mw.load_data : mw.result;
        end
    end

endmodule

// File: hdl/proc_top.sv
`timescale 1ns/1ps

module proc_top (
    input  logic                clock,
    input  logic                rst_n,
    output isa_pkg::pc_t        imem_addr,
    input  isa_pkg::word_t      imem_data,
    output pipe_pkg::dmem_req_t dmem,
    input  isa_pkg::word_t      dmem_rdata,
    output pipe_pkg::wb_t       wb
);

    pipe_pkg::fd_t       fd;
    pipe_pkg::dx_t       dx;
    pipe_pkg::xm_t       xm;
    pipe_pkg::redirect_t redirect;
    pipe_pkg::fwd_sel_e  fwd_a, fwd_b;
    isa_pkg::reg_idx_t   rs_idx, rt_idx;
    isa_pkg::word_t      rs_data, rt_data;
    logic                stall, flush_fd, flush_dx;

    // ------------------------------------------------------------------
    // Stages
    // ------------------------------------------------------------------
    fetch_stage fetch_stage_inst (
        .clock     (clock),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (flush_fd),
        .redirect  (redirect),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .fd        (fd)
    );

    decode_stage decode_stage_inst (
        .clock   (clock),
        .rst_n   (rst_n),
        .stall   (stall),
        .flush   (flush_dx),
        .fd      (fd),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .dx      (dx)
    );

    reg_file reg_file_inst (
        .clock   (clock),
        .rst_n   (rst_n),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb      (wb)
    );

    execute_stage execute_stage_inst (
        .clock     (clock),
        .rst_n     (rst_n),
        .dx        (dx),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .mw_bypass (wb),        // MW bypass is the write-back bus
        .redirect  (redirect),
        .xm        (xm)
    );

    mem_wb_stage mem_wb_stage_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .xm         (xm),
        .dmem       (dmem),
        .dmem_rdata (dmem_rdata),
        .wb         (wb)
    );

    // ------------------------------------------------------------------
    // Hazards, producer flags gated by valid
    // ------------------------------------------------------------------
    hazard_unit hazard_unit_inst (
        .fd_src_a   (rs_idx),
        .fd_src_b   (rt_idx),
        .dx_src_a   (dx.src_a),
        .dx_src_b   (dx.src_b),
        .dx_dst     (dx.dst),
        .xm_dst     (xm.dst),
        .mw_dst     (wb.idx),
        .dx_is_load (dx.valid && dx.ctrl.mem_to_reg),
        .xm_write   (xm.valid && xm.ctrl.reg_write),
        .mw_write   (wb.en),
        .redirect   (redirect),
        .stall      (stall),
        .flush_fd   (flush_fd),
        .flush_dx   (flush_dx),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b)
    );

endmodule

// File: tests/proc_checker.sv
`timescale 1ns/1ps

module proc_checker (
    input logic                clock,
    input logic                rst_n,
    input pipe_pkg::wb_t       wb,
    input pipe_pkg::dmem_req_t dmem
);

    // r0 is never a write-back target
    a_no_wb_r0: assert property (@(posedge clock) disable iff (!rst_n)
        !(wb.en && wb.idx == '0))
        else $error("write-back enabled for register zero");

    // Reset leaves the store strobe low
    a_wren_after_reset: assert property (@(posedge clock) !rst_n |=> !dmem.wren)
        else $error("store strobe high in the cycle after reset");

    a_known_outputs: assert property (@(posedge clock) disable iff (!rst_n)
        !$isunknown({wb, dmem}))    // Both buses fully driven
        else $error("unknown value on wb or dmem outside reset");

endmodule

bind proc_top proc_checker proc_checker_inst (
    .clock (clock),
    .rst_n (rst_n),
    .wb    (wb),
    .dmem  (dmem)
);

// File: tests/proc_tb.sv
`timescale 1ns/1ps

module proc_tb;

    localparam string GOLDEN_FILE = "tests/proc_golden.txt";
    localparam int    IMEM_WORDS  = 64;
    localparam int    DMEM_WORDS  = 64;
    localparam int    IAW         = $clog2(IMEM_WORDS);
    localparam int    DAW         = $clog2(DMEM_WORDS);
    localparam int    DRAIN       = 8;      // Covers the stages behind fetch

    logic                clock;
    logic                rst_n;
    isa_pkg::pc_t        imem_addr;
    isa_pkg::word_t      imem_data;
    pipe_pkg::dmem_req_t dmem;
    isa_pkg::word_t      dmem_rdata;
    pipe_pkg::wb_t       wb;

    isa_pkg::word_t    instr_mem [IMEM_WORDS];
    isa_pkg::word_t    data_mem  [DMEM_WORDS];
    isa_pkg::pc_t      init_addr [$];       // D entries, loaded during reset
    isa_pkg::word_t    init_data [$];
    isa_pkg::reg_idx_t wb_exp_idx [$];
    isa_pkg::word_t    wb_exp_data [$];
    isa_pkg::pc_t      st_exp_addr [$];
    isa_pkg::word_t    st_exp_data [$];

    int           prog_words   = 0;
    isa_pkg::pc_t loop_pc      = '0;        // Address of the final self-loop
    logic         loaded       = 1'b0;
    int           wb_errors    = 0;
    int           store_errors = 0;
    int           other_errors = 0;

    proc_top proc_top_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem       (dmem),
        .dmem_rdata (dmem_rdata),
        .wb         (wb)
    );

    always #5 clock = ~clock;               // 10 ns period

    // ------------------------------------------------------------------
    // Memory models
    // ------------------------------------------------------------------
    function automatic isa_pkg::word_t fill_word(input isa_pkg::pc_t addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_a5a5;
    endfunction

    assign imem_data  = (imem_addr < IMEM_WORDS) ? instr_mem[imem_addr[IAW-1:0]] : '0;
    assign dmem_rdata = (dmem.addr < DMEM_WORDS) ? data_mem[dmem.addr[DAW-1:0]]
                                                 : fill_word(dmem.addr);

    always @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                data_mem[i] <= fill_word(isa_pkg::pc_t'(i));
            end
            foreach (init_addr[k]) begin
                data_mem[init_addr[k][DAW-1:0]] <= init_data[k];   // Later write wins
            end
        end else if (dmem.wren && dmem.addr < DMEM_WORDS) begin
            data_mem[dmem.addr[DAW-1:0]] <= dmem.wdata;
        end
    end

    // ------------------------------------------------------------------
    // Golden file and compare tasks
    // ------------------------------------------------------------------

    // A j whose target is its own address ends the program
    function automatic logic is_self_loop(input isa_pkg::pc_t addr,
                                          input isa_pkg::word_t word);
        return word[isa_pkg::OPCODE_HI:isa_pkg::OPCODE_LO] == isa_pkg::op_j &&
               word[isa_pkg::TARGET_HI:isa_pkg::TARGET_LO] ==
               addr[isa_pkg::TARGET_HI:isa_pkg::TARGET_LO];
    endfunction

    task automatic load_golden();
        int          fh;
        int          c;
        int          n;
        logic [31:0] a;
        logic [31:0] b;
        logic        found;
        found = 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            instr_mem[i] = '0;              // add r0, r0, r0
        end
        fh = $fopen(GOLDEN_FILE, "r");
        if (fh == 0) begin
            $display("Cannot open the golden file %s", GOLDEN_FILE);
            other_errors++;
        end else begin
            c = $fgetc(fh);
            while (c != -1) begin
                if (c == int'("#")) begin
                    while (c != -1 && c != 10) begin    // Comment runs to end of line
                        c = $fgetc(fh);
                    end
                end else if (c == int'("I") || c == int'("D") ||
                             c == int'("W") || c == int'("S")) begin
                    n = $fscanf(fh, "%h %h", a, b);
                    if (n != 2) begin
                        $display("Golden entry %c does not have two hex fields", c[7:0]);
                        other_errors++;
                    end else begin
                        case (c)
                            int'("I"): begin
                                instr_mem[a[IAW-1:0]] = b;
                                prog_words++;
                                if (is_self_loop(a, b)) begin
                                    loop_pc = a;
                                    found   = 1'b1;
                                end
                            end
                            int'("D"): begin
                                init_addr.push_back(a);
                                init_data.push_back(b);
                            end
                            int'("W"): begin
                                wb_exp_idx.push_back(a[4:0]);
                                wb_exp_data.push_back(b);
                            end
                            default: begin
                                st_exp_addr.push_back(a);
                                st_exp_data.push_back(b);
                            end
                        endcase
                    end
                end else if (c > 32) begin
                    $display("Golden file holds an unknown tag %c", c[7:0]);
                    other_errors++;
                end
                if (c != -1) begin
                    c = $fgetc(fh);
                end
            end
            $fclose(fh);
            if (!found) begin
                $display("Golden program has no final self-loop");
                other_errors++;
            end
        end
    endtask

    task automatic check_wb(input isa_pkg::reg_idx_t idx, input isa_pkg::word_t data);
        isa_pkg::reg_idx_t exp_idx;
        isa_pkg::word_t    exp_data;
        if (wb_exp_idx.size() == 0) begin
            $display("Write-back of %h to r%0d at %0t was not expected", data, idx, $time);
            wb_errors++;
        end else begin
            exp_idx  = wb_exp_idx.pop_front();
            exp_data = wb_exp_data.pop_front();
            if (idx !== exp_idx) begin
                $display("** Error @ %0t: wb.idx = %0d, expected %0d", $time, idx, exp_idx);
                wb_errors++;
            end
            if (data !== exp_data) begin
                $display("** Error @ %0t: wb.data = %h, expected %h", $time, data, exp_data);
                wb_errors++;
            end
        end
    endtask

    task automatic check_store(input isa_pkg::pc_t addr, input isa_pkg::word_t data);
        isa_pkg::pc_t   exp_addr;
        isa_pkg::word_t exp_data;
        if (st_exp_addr.size() == 0) begin
            $display("Store of %h to address %h at %0t was not expected", data, addr, $time);
            store_errors++;
        end else begin
            exp_addr = st_exp_addr.pop_front();
            exp_data = st_exp_data.pop_front();
            if (addr !== exp_addr) begin
                $display("** Error @ %0t: dmem.addr = %h, expected %h", $time, addr, exp_addr);
                store_errors++;
            end
            if (data !== exp_data) begin
                $display("** Error @ %0t: dmem.wdata = %h, expected %h", $time, data, exp_data);
                store_errors++;
            end
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clock) begin
        if (rst_n) begin
            if (wb.en) check_wb(wb.idx, wb.data);
            if (dmem.wren) check_store(dmem.addr, dmem.wdata);
        end
    end

    // ------------------------------------------------------------------
    // Sequence and watchdog
    // ------------------------------------------------------------------
    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        load_golden();
        loaded = 1'b1;
        repeat (8) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        while (imem_addr !== loop_pc) begin     // Run until the final loop is fetched
            @(negedge clock);
        end
        repeat (DRAIN) @(negedge clock);        // Older work retires, extras show up
        @(posedge clock);
        if (wb_exp_idx.size() != 0) begin
            $display("%0d expected write-backs never appeared", wb_exp_idx.size());
            other_errors++;
        end
        if (st_exp_addr.size() != 0) begin
            $display("%0d expected stores never appeared", st_exp_addr.size());
            other_errors++;
        end
        $display("Errors: write-back %0d, store %0d, other %0d",
                 wb_errors, store_errors, other_errors);
        if (wb_errors + store_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (prog_words * 4 + 100) @(posedge clock);
        $display("Timeout, the program did not reach its final loop in %0d cycles",
                 prog_words * 4 + 100);
        $display("Errors: write-back %0d, store %0d, other %0d",
                 wb_errors, store_errors, other_errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: tests/proc_golden.txt
# I: instruction address, word. D: data address, initial word.
# W: expected register index, value. S: expected store address, data.
I 00000000 28400005  # addi r1, r0, 5
I 00000001 28820003  # addi r2, r1, 3       XM bypass
I 00000002 00c41004  # sub  r3, r2, r1      XM and MW bypass
I 00000003 01060210  # sll  r4, r3, 4
I 00000004 0148200c  # or   r5, r4, r2
I 00000005 018a4008  # and  r6, r5, r4
I 00000006 29c1fff0  # addi r7, r0, -16
I 00000007 020e0114  # sra  r8, r7, 2
I 00000008 28020007  # addi r0, r1, 7       discarded
I 00000009 02401000  # add  r9, r0, r1
I 0000000a 39420004  # sw   r5, 4(r1)
I 0000000b 42820004  # lw   r10, 4(r1)
I 0000000c 02d42000  # add  r11, r10, r2    load-use stall
I 0000000d 43020010  # lw   r12, 16(r1)
I 0000000e 10520005  # bne  r1, r9, 5       not taken
I 0000000f 30c20002  # blt  r3, r1, 2       taken to 18
I 00000010 2b400001  # addi r13, r0, 1      squashed
I 00000011 2b400002  # addi r13, r0, 2      squashed
I 00000012 10820001  # bne  r2, r1, 1       taken to 20
I 00000013 2b400003  # addi r13, r0, 3      squashed
I 00000014 1800001a  # jal  26
I 00000015 2b800009  # addi r14, r0, 9
I 00000016 08000018  # j    24
I 00000017 2bc00007  # addi r15, r0, 7      skipped
I 00000018 2c5c0001  # addi r17, r14, 1
I 00000019 08000019  # j    25              final loop
I 0000001a 2c3e0064  # addi r16, r31, 100
I 0000001b 27c00000  # jr   r31
D 00000015 cafe0001
W 00000001 00000005
W 00000002 00000008
W 00000003 00000003
W 00000004 00000030
W 00000005 00000038
W 00000006 00000030
W 00000007 fffffff0
W 00000008 fffffffc
W 00000009 00000005
S 00000009 00000038
W 0000000a 00000038
W 0000000b 00000040
W 0000000c cafe0001
W 0000001f 00000015
W 00000010 00000079
W 0000000e 00000009
W 00000011 0000000a

// File: build.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/hazard_unit.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/proc_top.sv
tests/proc_checker.sv
tests/proc_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= proc_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
